//--- src/sd_pkg.sv
////////////////////
// SD host package
// request and response types for the SD SPI host handshake
////////////////////
package sd_pkg;

    localparam int sd_block_bytes = 512;

    // command levels, each held until busy falls
    typedef struct packed {
        logic        rst;
        logic        r_block;
        logic        r_byte;
        logic        w_block;
        logic        w_byte;
        logic [31:0] block_addr;
        logic [7:0]  data_in;
    } sd_req_t;

    typedef struct packed {
        logic       busy;
        logic [7:0] data_out;
        logic       err;
    } sd_rsp_t;

endpackage

//--- src/autotest_pkg.sv
////////////////////
// autotest package
// configuration block layout and UUT parameter types
////////////////////
package autotest_pkg;

    localparam logic [31:0] autotest_signature = 32'hAABBCCDD;
    localparam int          n_blocks_bytes     = 4;
    localparam int          hdr_bytes          = 11;

    // header byte offsets, signature sits at 0..3 big endian
    localparam int off_iter     = 4;
    localparam int off_n_blocks = 5;
    localparam int off_sclk     = off_n_blocks + n_blocks_bytes;
    localparam int off_cmd18    = off_sclk + 1;

    typedef struct packed {
        logic [7:0]  iterations;
        logic [31:0] n_blocks;
        logic [7:0]  sclk_speed;
        logic [7:0]  cmd18;
    } uut_cfg_t;

    // one run time in clk cycles
    typedef logic [31:0] timing_t;

endpackage

//--- src/sd_block_reader.sv
`timescale 1ns/1ps
////////////////////
// SD block reader
// resets the host, opens a block and reads it byte by byte
////////////////////
module sd_block_reader
    import sd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic [31:0] block_addr_i,
    input  sd_rsp_t     sd_rsp_i,
    output sd_req_t     sd_req_o,
    output logic        byte_valid_o,
    output logic [7:0]  byte_o,
    output logic [8:0]  offset_o,
    output logic        block_done_o
);

    typedef enum logic [3:0] {
        S_IDLE, S_RST, S_RST_W, S_BLK, S_BLK_W, S_BYTE, S_BYTE_W, S_NEXT, S_FIN
    } state_t;

    state_t     state;
    logic [8:0] cnt;
    logic       byte_ack;

    assign byte_ack = (state == S_BYTE_W) && !sd_rsp_i.busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= S_IDLE;
            cnt          <= '0;
            byte_valid_o <= 1'b0;
            block_done_o <= 1'b0;
        end
        else
        begin
            byte_valid_o <= byte_ack;
            block_done_o <= 1'b0;
            case (state)
                S_IDLE:
                    if (start_i)
                    begin
                        cnt   <= '0;
                        state <= S_RST;
                    end
                S_RST:    if (sd_rsp_i.busy) state <= S_RST_W;
                S_RST_W:  if (!sd_rsp_i.busy) state <= S_BLK;
                S_BLK:    if (sd_rsp_i.busy) state <= S_BLK_W;
                S_BLK_W:  if (!sd_rsp_i.busy) state <= S_BYTE;
                S_BYTE:   if (sd_rsp_i.busy) state <= S_BYTE_W;
                S_BYTE_W:
                    if (byte_ack)
                    begin
                        cnt   <= cnt + 9'd1;
                        state <= (cnt == 9'(sd_block_bytes - 1)) ? S_FIN : S_NEXT;
                    end
                // one low cycle on r_byte between bytes
                S_NEXT:   state <= S_BYTE;
                S_FIN:
                begin
                    block_done_o <= 1'b1;
                    state        <= S_IDLE;
                end
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_ack)
        begin
            byte_o   <= sd_rsp_i.data_out;
            offset_o <= cnt;
        end
    end

    always_comb
    begin
        sd_req_o            = '0;
        sd_req_o.block_addr = block_addr_i;
        sd_req_o.rst        = (state == S_RST) || (state == S_RST_W);
        sd_req_o.r_block    = state inside {S_BLK, S_BLK_W, S_BYTE, S_BYTE_W, S_NEXT};
        sd_req_o.r_byte     = (state == S_BYTE) || (state == S_BYTE_W);
    end

endmodule

//--- src/config_parser.sv
`timescale 1ns/1ps
////////////////////
// configuration parser
// decodes the block header, forwards payload to the buffer
////////////////////
module config_parser
    import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        byte_valid_i,
    input  logic [7:0]  byte_i,
    input  logic [8:0]  offset_i,
    output uut_cfg_t    cfg_o,
    output logic [31:0] signature_o,
    output logic        sig_ok_o,
    output logic        buf_we_o,
    output logic [8:0]  buf_addr_o,
    output logic [7:0]  buf_din_o
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cfg_o       <= '0;
            signature_o <= '0;
        end
        else if (byte_valid_i)
        begin
            // big endian, first byte ends up on top
            if (offset_i < 9'(off_iter))
                signature_o <= {signature_o[23:0], byte_i};
            if (offset_i == 9'(off_iter))
                cfg_o.iterations <= byte_i;
            for (int k = 0; k < n_blocks_bytes; k++)
            begin
                if (offset_i == 9'(off_n_blocks + k))
                    cfg_o.n_blocks[8 * k +: 8] <= byte_i;
            end
            if (offset_i == 9'(off_sclk))
                cfg_o.sclk_speed <= byte_i;
            if (offset_i == 9'(off_cmd18))
                cfg_o.cmd18 <= byte_i;
        end
    end

    assign sig_ok_o = (signature_o == autotest_signature);

    // everything past the header is kept for copy-back
    assign buf_we_o   = byte_valid_i && (offset_i >= 9'(hdr_bytes));
    assign buf_addr_o = offset_i;
    assign buf_din_o  = byte_i;

endmodule

//--- src/payload_buffer.sv
`timescale 1ns/1ps
////////////////////
// payload buffer
// one block of bytes, registered read
////////////////////
module payload_buffer
    import sd_pkg::*;
(
    input  logic       clk,
    input  logic       we_i,
    input  logic [8:0] addr_i,
    input  logic [7:0] din_i,
    output logic [7:0] dout_o
);

    logic [7:0] mem [0:sd_block_bytes-1];

    always_ff @(posedge clk)
    begin
        if (we_i)
            mem[addr_i] <= din_i;
        dout_o <= mem[addr_i];
    end

endmodule

//--- src/test_sequencer.sv
`timescale 1ns/1ps
////////////////////
// test sequencer
// read, run the UUT n times with timeout, write results
////////////////////
module test_sequencer
    import autotest_pkg::*;
#(
    parameter int          max_iter       = 16,
    parameter int          timeout_cycles = 2000,
    parameter logic [31:0] start_block    = 32'd0,
    parameter logic [31:0] result_offset  = 32'd256
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  uut_cfg_t               cfg_i,
    input  logic                   sig_ok_i,
    input  logic                   block_done_i,
    input  logic                   write_done_i,
    output logic                   read_start_o,
    output logic                   write_start_o,
    output logic                   write_phase_o,
    output logic [31:0]            block_addr_o,
    output timing_t [max_iter-1:0] timings_o,
    output logic                   uut_rst_o,
    output logic                   uut_start_o,
    input  logic                   uut_finish_i,
    output logic [31:0]            uut_n_blocks_o,
    output logic [7:0]             uut_sclk_speed_o,
    output logic [7:0]             uut_cmd18_o,
    output logic                   done_o
);

    typedef enum logic [3:0] {
        S_IDLE, S_READ, S_WAIT_RD, S_PREP, S_RUN, S_GAP, S_WRITE, S_WAIT_WR, S_DONE
    } state_t;

    state_t      state;
    logic [31:0] blk_cnt;
    logic [31:0] cfg_addr;
    logic [7:0]  iter_lim;
    logic [7:0]  iter_cnt;
    timing_t     timer;
    timing_t     timer_nxt;
    logic        run_end;

    assign timer_nxt = timer + 32'd1;
    assign run_end   = uut_finish_i || (timer_nxt == timing_t'(timeout_cycles));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= S_IDLE;
            blk_cnt   <= '0;
            iter_lim  <= '0;
            iter_cnt  <= '0;
            timer     <= '0;
            timings_o <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:    state <= S_READ;
                S_READ:    state <= S_WAIT_RD;
                S_WAIT_RD:
                    if (block_done_i)
                    begin
                        if (!sig_ok_i)
                            state <= S_DONE;
                        else
                            state <= S_PREP;
                        if (cfg_i.iterations > 8'(max_iter))
                            iter_lim <= 8'(max_iter);
                        else
                            iter_lim <= cfg_i.iterations;
                    end
                S_PREP:
                begin
                    iter_cnt  <= '0;
                    timings_o <= '0;
                    state     <= (iter_lim == 8'd0) ? S_WRITE : S_RUN;
                end
                S_RUN:
                    if (run_end)
                    begin
                        timings_o[iter_cnt] <= timer_nxt;
                        iter_cnt            <= iter_cnt + 8'd1;
                        timer               <= '0;
                        state               <= S_GAP;
                    end
                    else
                        timer <= timer_nxt;
                // UUT held in reset here before the next run
                S_GAP:     state <= (iter_cnt < iter_lim) ? S_RUN : S_WRITE;
                S_WRITE:   state <= S_WAIT_WR;
                S_WAIT_WR:
                    if (write_done_i)
                    begin
                        blk_cnt <= blk_cnt + 32'd1;
                        state   <= S_READ;
                    end
                S_DONE:    state <= S_DONE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    assign cfg_addr      = start_block + blk_cnt;
    assign block_addr_o  = write_phase_o ? cfg_addr + result_offset : cfg_addr;

    assign read_start_o  = (state == S_READ);
    assign write_start_o = (state == S_WRITE);
    assign write_phase_o = (state == S_WRITE) || (state == S_WAIT_WR);
    assign uut_start_o   = (state == S_RUN);
    assign uut_rst_o     = (state != S_RUN);
    assign done_o        = (state == S_DONE);

    assign uut_n_blocks_o   = cfg_i.n_blocks;
    assign uut_sclk_speed_o = cfg_i.sclk_speed;
    assign uut_cmd18_o      = cfg_i.cmd18;

endmodule

//--- src/result_writer.sv
`timescale 1ns/1ps
////////////////////
// result writer
// writes header, run timings and payload copy to one block
////////////////////
module result_writer
    import sd_pkg::*;
    import autotest_pkg::*;
#(
    parameter int max_iter = 16
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  logic [31:0]            block_addr_i,
    input  logic [31:0]            signature_i,
    input  uut_cfg_t               cfg_i,
    input  timing_t [max_iter-1:0] timings_i,
    output logic [8:0]             buf_addr_o,
    input  logic [7:0]             buf_dout_i,
    input  sd_rsp_t                sd_rsp_i,
    output sd_req_t                sd_req_o,
    output logic                   done_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_BLK, S_BLK_W, S_NEXT, S_BYTE, S_BYTE_W, S_FIN
    } state_t;

    state_t     state;
    logic [8:0] cnt;
    logic [8:0] rel;
    logic [7:0] wr_byte;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (start_i)
                    begin
                        cnt   <= '0;
                        state <= S_BLK;
                    end
                S_BLK:    if (sd_rsp_i.busy) state <= S_BLK_W;
                S_BLK_W:  if (!sd_rsp_i.busy) state <= S_NEXT;
                // buffer read of the new offset lands here
                S_NEXT:   state <= S_BYTE;
                S_BYTE:   if (sd_rsp_i.busy) state <= S_BYTE_W;
                S_BYTE_W:
                    if (!sd_rsp_i.busy)
                    begin
                        cnt   <= cnt + 9'd1;
                        state <= (cnt == 9'(sd_block_bytes - 1)) ? S_FIN : S_NEXT;
                    end
                S_FIN:    state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    assign buf_addr_o = cnt;
    assign done_o     = (state == S_FIN);

    // byte select by offset
    always_comb
    begin
        rel     = cnt - 9'(hdr_bytes);
        wr_byte = buf_dout_i;
        if (cnt < 9'(off_iter))
            wr_byte = signature_i[8 * (3 - cnt[1:0]) +: 8];
        else if (cnt == 9'(off_iter))
            wr_byte = cfg_i.iterations;
        else if (cnt < 9'(off_sclk))
            wr_byte = cfg_i.n_blocks[8 * (cnt - 9'(off_n_blocks)) +: 8];
        else if (cnt == 9'(off_sclk))
            wr_byte = cfg_i.sclk_speed;
        else if (cnt == 9'(off_cmd18))
            wr_byte = cfg_i.cmd18;
        else if (int'(rel) < 4 * max_iter)
            wr_byte = timings_i[rel[8:2]][8 * rel[1:0] +: 8];
    end

    always_comb
    begin
        sd_req_o            = '0;
        sd_req_o.block_addr = block_addr_i;
        sd_req_o.w_block    = state inside {S_BLK, S_BLK_W, S_NEXT, S_BYTE, S_BYTE_W};
        sd_req_o.w_byte     = (state == S_BYTE) || (state == S_BYTE_W);
        sd_req_o.data_in    = wr_byte;
    end

endmodule

//--- src/autotest_top.sv
`timescale 1ns/1ps
////////////////////
// autotest top
// SD driven self-test controller for one UUT
////////////////////
module autotest_top
    import sd_pkg::*;
    import autotest_pkg::*;
#(
    parameter int          max_iter       = 16,
    parameter int          timeout_cycles = 2000,
    parameter logic [31:0] start_block    = 32'd0,
    parameter logic [31:0] result_offset  = 32'd256
)
(
    input  logic        clk,
    input  logic        rst,
    output sd_req_t     sd_req_o,
    input  sd_rsp_t     sd_rsp_i,
    output logic        uut_rst_o,
    output logic        uut_start_o,
    input  logic        uut_finish_i,
    output logic [31:0] uut_n_blocks_o,
    output logic [7:0]  uut_sclk_speed_o,
    output logic [7:0]  uut_cmd18_o,
    output logic        done_o
);

    sd_req_t                rd_req;
    sd_req_t                wr_req;
    logic                   read_start;
    logic                   write_start;
    logic                   write_phase;
    logic                   write_done;
    logic [31:0]            block_addr;
    logic                   byte_valid;
    logic [7:0]             rd_byte;
    logic [8:0]             rd_offset;
    logic                   block_done;
    uut_cfg_t               cfg;
    logic [31:0]            signature;
    logic                   sig_ok;
    timing_t [max_iter-1:0] timings;
    logic                   buf_we;
    logic [8:0]             parser_addr;
    logic [8:0]             writer_addr;
    logic [8:0]             buf_addr;
    logic [7:0]             buf_din;
    logic [7:0]             buf_dout;

    // only one side talks to the host at a time
    assign sd_req_o = write_phase ? wr_req : rd_req;
    assign buf_addr = write_phase ? writer_addr : parser_addr;

    sd_block_reader sd_block_reader_inst (
        .clk          (clk),
        .rst          (rst),
        .start_i      (read_start),
        .block_addr_i (block_addr),
        .sd_rsp_i     (sd_rsp_i),
        .sd_req_o     (rd_req),
        .byte_valid_o (byte_valid),
        .byte_o       (rd_byte),
        .offset_o     (rd_offset),
        .block_done_o (block_done)
    );

    config_parser config_parser_inst (
        .clk          (clk),
        .rst          (rst),
        .byte_valid_i (byte_valid),
        .byte_i       (rd_byte),
        .offset_i     (rd_offset),
        .cfg_o        (cfg),
        .signature_o  (signature),
        .sig_ok_o     (sig_ok),
        .buf_we_o     (buf_we),
        .buf_addr_o   (parser_addr),
        .buf_din_o    (buf_din)
    );

    payload_buffer payload_buffer_inst (
        .clk    (clk),
        .we_i   (buf_we),
        .addr_i (buf_addr),
        .din_i  (buf_din),
        .dout_o (buf_dout)
    );

    test_sequencer #(
        .max_iter       (max_iter),
        .timeout_cycles (timeout_cycles),
        .start_block    (start_block),
        .result_offset  (result_offset)
    ) test_sequencer_inst (
        .clk              (clk),
        .rst              (rst),
        .cfg_i            (cfg),
        .sig_ok_i         (sig_ok),
        .block_done_i     (block_done),
        .write_done_i     (write_done),
        .read_start_o     (read_start),
        .write_start_o    (write_start),
        .write_phase_o    (write_phase),
        .block_addr_o     (block_addr),
        .timings_o        (timings),
        .uut_rst_o        (uut_rst_o),
        .uut_start_o      (uut_start_o),
        .uut_finish_i     (uut_finish_i),
        .uut_n_blocks_o   (uut_n_blocks_o),
        .uut_sclk_speed_o (uut_sclk_speed_o),
        .uut_cmd18_o      (uut_cmd18_o),
        .done_o           (done_o)
    );

    result_writer #(
        .max_iter (max_iter)
    ) result_writer_inst (
        .clk          (clk),
        .rst          (rst),
        .start_i      (write_start),
        .block_addr_i (block_addr),
        .signature_i  (signature),
        .cfg_i        (cfg),
        .timings_i    (timings),
        .buf_addr_o   (writer_addr),
        .buf_dout_i   (buf_dout),
        .sd_rsp_i     (sd_rsp_i),
        .sd_req_o     (wr_req),
        .done_o       (write_done)
    );

endmodule

//--- tb/sd_host_model.sv
`timescale 1ns/1ps
////////////////////
// SD host and UUT model
// block store behind a busy handshake, UUT finish after a set delay
////////////////////
module sd_host_model
    import sd_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sd_req_t sd_req_i,
    output sd_rsp_t sd_rsp_o,
    input  logic    uut_start_i,
    input  logic    uut_rst_i,
    output logic    uut_finish_o
);

    localparam int n_blocks = 512;

    logic [7:0] mem [0:n_blocks*sd_block_bytes-1];
    int         delay_tab [0:31];
    int         wr_count [0:n_blocks-1];
    int         blocks_written;
    int         runs_done;
    int         run_cnt;
    logic       start_q;

    sd_req_t    req_q;
    sd_rsp_t    rsp_r;
    int         lat;
    int         op_cnt;
    logic [8:0] blk;
    logic [8:0] idx;
    logic       pend_rd;
    logic       pend_wr;
    logic       blk_rise;
    logic       cmd_rise;
    logic       finish_c;

    assign blk_rise = (sd_req_i.r_block && !req_q.r_block)
                      || (sd_req_i.w_block && !req_q.w_block);
    assign cmd_rise = blk_rise || (sd_req_i.rst && !req_q.rst)
                      || (sd_req_i.r_byte && !req_q.r_byte)
                      || (sd_req_i.w_byte && !req_q.w_byte);

    // background pattern over every block
    initial
    begin
        for (int a = 0; a < n_blocks * sd_block_bytes; a++)
            mem[a] = 8'(a ^ (a >> 8) ^ (a >> 16));
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            req_q          <= '0;
            rsp_r          <= '0;
            lat            <= 0;
            op_cnt         <= 0;
            pend_rd        <= 1'b0;
            pend_wr        <= 1'b0;
            blk            <= '0;
            idx            <= '0;
            blocks_written <= 0;
            for (int b = 0; b < n_blocks; b++)
                wr_count[b] <= 0;
        end
        else
        begin
            req_q <= sd_req_i;
            if (rsp_r.busy)
            begin
                if (lat == 0)
                begin
                    rsp_r.busy <= 1'b0;
                    if (pend_rd)
                        rsp_r.data_out <= mem[{blk, idx}];
                    if (pend_wr)
                        mem[{blk, idx}] <= sd_req_i.data_in;
                    if (pend_rd || pend_wr)
                        idx <= idx + 9'd1;
                end
                else
                    lat <= lat - 1;
            end
            else if (cmd_rise)
            begin
                // busy length steps through 1..3 cycles
                rsp_r.busy <= 1'b1;
                lat        <= op_cnt % 3;
                op_cnt     <= op_cnt + 1;
                pend_rd    <= sd_req_i.r_byte && !req_q.r_byte;
                pend_wr    <= sd_req_i.w_byte && !req_q.w_byte;
                if (blk_rise)
                begin
                    blk <= sd_req_i.block_addr[8:0];
                    idx <= '0;
                end
                if (sd_req_i.w_block && !req_q.w_block)
                    wr_count[sd_req_i.block_addr[8:0]] <= wr_count[sd_req_i.block_addr[8:0]] + 1;
            end
            if (req_q.w_block && !sd_req_i.w_block)
                blocks_written <= blocks_written + 1;
        end
    end

    // UUT side, edges counted while start is high
    always @(posedge clk)
    begin
        if (rst)
        begin
            start_q   <= 1'b0;
            run_cnt   <= 0;
            runs_done <= 0;
        end
        else
        begin
            start_q <= uut_start_i;
            run_cnt <= uut_start_i ? run_cnt + 1 : 0;
            if (start_q && !uut_start_i)
                runs_done <= runs_done + 1;
        end
    end

    assign finish_c = (uut_start_i === 1'b1) && (uut_rst_i === 1'b0)
                      && (run_cnt + 1 == delay_tab[runs_done]);

    // outputs follow 2 ns after they change
    initial
    begin
        sd_rsp_o     = '0;
        uut_finish_o = 1'b0;
        forever
        begin
            @(rsp_r or finish_c);
            sd_rsp_o     <= #2 rsp_r;
            uut_finish_o <= #2 finish_c;
        end
    end

endmodule

//--- tb/autotest_tb.sv
`timescale 1ns/1ps
////////////////////
// autotest testbench
// three config blocks, checks UUT runs and the result blocks
////////////////////
module autotest_tb
    import sd_pkg::*;
    import autotest_pkg::*;
();

    localparam int max_iter_c   = 16;
    localparam int timeout_c    = 2000;
    localparam int start_blk_c  = 8;
    localparam int result_off_c = 256;
    localparam int n_cfg        = 3;
    localparam int n_runs       = 5;
    localparam int wait_limit   = 100000;

    logic        clk;
    logic        rst;
    sd_req_t     sd_req;
    sd_rsp_t     sd_rsp;
    logic        uut_rst;
    logic        uut_start;
    logic        uut_finish;
    logic [31:0] uut_n_blocks;
    logic [7:0]  uut_sclk;
    logic [7:0]  uut_cmd18;
    logic        done;

    logic [31:0] rng;
    logic [7:0]  src [0:n_cfg-1][0:sd_block_bytes-1];
    int          run_delay [0:n_runs-1];
    int          test_err [1:6];
    int          checks;
    int          runs_seen;
    int          total_err;
    logic        start_q;
    logic        rst_q;
    bit          ok;

    autotest_top #(
        .max_iter       (max_iter_c),
        .timeout_cycles (timeout_c),
        .start_block    (start_blk_c),
        .result_offset  (result_off_c)
    ) autotest_top_inst (
        .clk              (clk),
        .rst              (rst),
        .sd_req_o         (sd_req),
        .sd_rsp_i         (sd_rsp),
        .uut_rst_o        (uut_rst),
        .uut_start_o      (uut_start),
        .uut_finish_i     (uut_finish),
        .uut_n_blocks_o   (uut_n_blocks),
        .uut_sclk_speed_o (uut_sclk),
        .uut_cmd18_o      (uut_cmd18),
        .done_o           (done)
    );

    sd_host_model sd_host_model_inst (
        .clk          (clk),
        .rst          (rst),
        .sd_req_i     (sd_req),
        .sd_rsp_o     (sd_rsp),
        .uut_start_i  (uut_start),
        .uut_rst_i    (uut_rst),
        .uut_finish_o (uut_finish)
    );

    initial
        clk = 1'b0;

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_eq(input int t, input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("MISMATCH at %0t ns: test %0d %s, got %0h expected %0h",
                     $time, t, what, got, exp);
            test_err[t]++;
        end
    endtask

    task automatic check_true(input int t, input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            $display("test %0d failed at %0t ns: %s", t, $time, what);
            test_err[t]++;
        end
    endtask

    task automatic report_test(input int t, input string name);
        $display("test %0d %s: %s, %0d errors", t, name,
                 (test_err[t] == 0) ? "pass" : "fail", test_err[t]);
    endtask

    // header per the block layout, random payload, then into the host store
    task automatic build_block(input int b, input logic [7:0] iter, input bit good);
        logic [31:0] sig;
        int          base;
        sig = good ? autotest_signature : (autotest_signature ^ 32'h1);
        for (int k = 0; k < 4; k++)
            src[b][k] = sig[8 * (3 - k) +: 8];
        src[b][4] = iter;
        rng = next_random(rng);
        for (int k = 0; k < 4; k++)
            src[b][5 + k] = rng[8 * k +: 8];
        rng = next_random(rng);
        src[b][9]  = rng[7:0];
        src[b][10] = {7'd0, rng[16]};
        for (int o = 11; o < sd_block_bytes; o++)
        begin
            rng = next_random(rng);
            src[b][o] = rng[7:0];
        end
        base = (start_blk_c + b) * sd_block_bytes;
        for (int o = 0; o < sd_block_bytes; o++)
            sd_host_model_inst.mem[base + o] = src[b][o];
    endtask

    task automatic check_result(input int b, input int first_run);
        int          blk;
        int          slot;
        int          delay;
        logic [31:0] exp_slot;
        logic [7:0]  got;
        blk = start_blk_c + result_off_c + b;
        for (int o = 0; o < sd_block_bytes; o++)
        begin
            got = sd_host_model_inst.mem[blk * sd_block_bytes + o];
            if (o < 11 || o >= 11 + 4 * max_iter_c)
                check_eq(4, $sformatf("block %0d byte %0d", blk, o), got, src[b][o]);
            else
            begin
                slot     = (o - 11) / 4;
                delay    = (slot < src[b][4]) ? run_delay[first_run + slot] : 0;
                exp_slot = (delay > timeout_c) ? timeout_c : delay;
                check_eq((delay > timeout_c) ? 3 : 2,
                         $sformatf("block %0d slot %0d byte %0d", blk, slot, (o - 11) % 4),
                         got, exp_slot[8 * ((o - 11) % 4) +: 8]);
            end
        end
    endtask

    task automatic wait_writes(input int n, output bit got);
        int cycles;
        cycles = 0;
        while (sd_host_model_inst.blocks_written < n && cycles < wait_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        got = (sd_host_model_inst.blocks_written >= n);
        if (!got)
            $display("timeout: result block %0d was never written", n);
    endtask

    task automatic wait_done(output bit got);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < wait_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        got = (done === 1'b1);
        if (!got)
            $display("timeout: done_o never rose after the last result block");
    endtask

    // run monitor, sampled mid-cycle
    always @(negedge clk)
    begin
        int b;
        if (!rst)
        begin
            if (uut_start && !start_q)
            begin
                check_true(5, rst_q, "uut_rst_o was low in the cycle before a run");
                runs_seen++;
            end
            check_true(5, uut_start || uut_rst, "uut_rst_o low between runs");
            if (uut_start)
            begin
                check_true(5, !(sd_req.r_block || sd_req.w_block),
                           "uut_start_o high during a block transfer");
                b = (runs_seen <= 3) ? 0 : 1;
                check_eq(1, "uut_n_blocks_o", uut_n_blocks,
                         {src[b][8], src[b][7], src[b][6], src[b][5]});
                check_eq(1, "uut_sclk_speed_o", uut_sclk, src[b][9]);
                check_eq(1, "uut_cmd18_o", uut_cmd18, src[b][10]);
            end
            start_q <= uut_start;
            rst_q   <= uut_rst;
        end
    end

    initial
    begin
        rst       = 1'b1;
        rng       = 32'hbfa;
        checks    = 0;
        runs_seen = 0;
        start_q   = 1'b0;
        rst_q     = 1'b1;
        ok        = 1'b1;
        for (int t = 1; t <= 6; t++)
            test_err[t] = 0;

        @(posedge clk);
        #2;
        build_block(0, 8'd3, 1'b1);
        build_block(1, 8'd2, 1'b1);
        build_block(2, 8'd3, 1'b0);
        for (int r = 0; r < n_runs; r++)
        begin
            rng = next_random(rng);
            run_delay[r] = 5 + int'(rng % 300);
        end
        // second run of block 9 overruns the timeout
        run_delay[4] = timeout_c + 500;
        for (int r = 0; r < 32; r++)
            sd_host_model_inst.delay_tab[r] = (r < n_runs) ? run_delay[r] : 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        wait_writes(1, ok);
        if (ok)
        begin
            check_result(0, 0);
            wait_writes(2, ok);
        end
        if (ok)
        begin
            check_result(1, 3);
            report_test(2, "run timing slots");
            report_test(3, "timeout capture");
            report_test(4, "header and payload copy");
            wait_done(ok);
        end
        if (ok)
        begin
            repeat (200) @(posedge clk);
            check_true(6, done === 1'b1, "done_o dropped after the bad signature");
            check_eq(6, "blocks written", sd_host_model_inst.blocks_written, 2);
            check_eq(6, "writes to block 264", sd_host_model_inst.wr_count[264], 1);
            check_eq(6, "writes to block 265", sd_host_model_inst.wr_count[265], 1);
            check_eq(6, "UUT runs", runs_seen, n_runs);
            report_test(1, "config outputs during runs");
            report_test(5, "uut reset and start ordering");
            report_test(6, "stop on bad signature");
        end

        total_err = 0;
        for (int t = 1; t <= 6; t++)
            total_err += test_err[t];
        $display("summary: 6 tests, %0d checks, %0d errors", checks, total_err);
        if (ok && total_err == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- flist.f
src/sd_pkg.sv
src/autotest_pkg.sv
src/sd_block_reader.sv
src/config_parser.sv
src/payload_buffer.sv
src/test_sequencer.sv
src/result_writer.sv
src/autotest_top.sv
tb/sd_host_model.sv
tb/autotest_tb.sv
